/* adpcmb.f */
+incdir+include
hdl/adpcmb_codec_pkg.sv
hdl/adpcmb_ctrl_pkg.sv
hdl/adpcmb_decode.sv
hdl/adpcmb_div.sv
hdl/adpcmb_interp.sv
hdl/adpcmb_top.sv
tests/adpcmb_chk.sv
tests/adpcmb_tb.sv

/* hdl/adpcmb_codec_pkg.sv */
package adpcmb_codec_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sample and code words
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef logic signed [15:0] pcm_t;          // Decoded 16-bit sample

    typedef struct packed {
        logic       sign;                       // Set means subtract
        logic [2:0] mag;                        // Magnitude, picks multiplier
    } nibble_t;                                 // One ADPCM-B code

    localparam pcm_t PCM_MAX = 16'sh7fff;       // Saturation limits
    localparam pcm_t PCM_MIN = -16'sh8000;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Adaptive step
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef logic [14:0] step_t;                // Unsigned step size

    localparam step_t STEP_MIN = 15'd127;       // Also the start value
    localparam step_t STEP_MAX = 15'd24576;

    // Multipliers are in 1/64 units
    localparam int STEP_FRAC_W = 6;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Interpolation interval
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef logic [3:0] dn_t;                   // Output ticks per sample, 1..15

endpackage

/* hdl/adpcmb_ctrl_pkg.sv */
package adpcmb_ctrl_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage strobes, all one enabled cycle wide
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic                      adv;         // Output side wants a new code
        adpcmb_codec_pkg::nibble_t nibble;      // Code for this advance
    } nib_strobe_t;

    typedef struct packed {
        logic                   stb;            // New decoded sample
        adpcmb_codec_pkg::pcm_t pcm;
    } sample_strobe_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Divider request and response
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic        start;                     // Load operands, begin
        logic [15:0] dividend;                  // Unsigned
        logic [15:0] divisor;                   // Never zero
    } div_req_t;

    typedef struct packed {
        logic        done;                      // Quotient valid this cycle
        logic [15:0] quotient;                  // Truncated
    } div_rsp_t;

endpackage

/* hdl/adpcmb_decode.sv */
`timescale 1ns/100ps

module adpcmb_decode (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            cen,     // Internal clock enable
    input  adpcmb_ctrl_pkg::nib_strobe_t    nib_in,  // Code plus advance
    output adpcmb_ctrl_pkg::sample_strobe_t sample   // Decoded sample strobe
);

`include "adpcmb_step_table.svh"

adpcmb_codec_pkg::nibble_t nib_r;    // Code under decode
logic                      go1;      // Code registered
logic                      go2;      // Delta ready
adpcmb_codec_pkg::step_t   step_r;   // Adaptive step
logic [15:0]               diff_r;   // Unsigned delta
logic                      neg_r;    // Delta sign
adpcmb_codec_pkg::pcm_t    acc;      // Predictor, also the output
logic                      stb_r;

logic [18:0]               diff_prod; // (2m+1)*step
logic [22:0]               step_prod; // step*mult
logic [16:0]               step_scl;  // step*mult/64
adpcmb_codec_pkg::step_t   step_nxt;
logic signed [17:0]        sum;       // Room for overflow both ways

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Delta and next step, both from the current step
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
always_comb begin
    diff_prod = 19'({nib_r.mag, 1'b1}) * 19'(step_r);
    step_prod = 23'(step_r) * 23'(ADPCMB_STEP_MULT[nib_r.mag]);
    step_scl  = step_prod[22:adpcmb_codec_pkg::STEP_FRAC_W];
    if (step_scl < 17'(adpcmb_codec_pkg::STEP_MIN))
        step_nxt = adpcmb_codec_pkg::STEP_MIN;
    else if (step_scl > 17'(adpcmb_codec_pkg::STEP_MAX))
        step_nxt = adpcmb_codec_pkg::STEP_MAX;
    else
        step_nxt = step_scl[14:0];
    sum = neg_r ? {{2{acc[15]}}, acc} - {2'b00, diff_r}   // Sign-extend predictor
                : {{2{acc[15]}}, acc} + {2'b00, diff_r};
end

// Three enabled stages: latch, delta, accumulate
always_ff @(posedge clk) begin
    if (!rst_n) begin
        go1    <= 1'b0;
        go2    <= 1'b0;
        stb_r  <= 1'b0;
        step_r <= adpcmb_codec_pkg::STEP_MIN;   // Start step
        acc    <= '0;
    end else if (cen) begin
        go1   <= nib_in.adv;
        go2   <= go1;
        stb_r <= go2;                           // Two cen after adv
        if (nib_in.adv)
            nib_r <= nib_in.nibble;
        if (go1) begin
            diff_r <= diff_prod[18:3];          // Divide by 8
            neg_r  <= nib_r.sign;
            step_r <= step_nxt;
        end
        if (go2) begin
            if (sum[17:15] == 3'b000 || sum[17:15] == 3'b111)
                acc <= sum[15:0];               // In range
            else
                acc <= sum[17] ? adpcmb_codec_pkg::PCM_MIN : adpcmb_codec_pkg::PCM_MAX;
        end
    end
end

assign sample.stb = stb_r;
assign sample.pcm = acc;

endmodule

/* hdl/adpcmb_div.sv */
`timescale 1ns/100ps

module adpcmb_div #(
    parameter int DIV_W = 16                    // Operand and quotient width
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      cen,
    input  adpcmb_ctrl_pkg::div_req_t req,
    output adpcmb_ctrl_pkg::div_rsp_t rsp
);

localparam int CNT_W = $clog2(DIV_W + 1);

logic [DIV_W-1:0] rem;     // Partial remainder
logic [DIV_W-1:0] quo;     // Dividend shifts out, quotient in
logic [DIV_W-1:0] den;     // Divisor held for the run
logic [CNT_W-1:0] cnt;     // Bits left
logic             busy;
logic             done_r;

logic [DIV_W:0]   rem_sh;  // Remainder with next dividend bit
logic [DIV_W:0]   trial;   // Trial subtraction

always_comb begin
    rem_sh = {rem, quo[DIV_W-1]};
    trial  = rem_sh - {1'b0, den};
end

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Restoring loop, one quotient bit per enabled cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
always_ff @(posedge clk) begin
    if (!rst_n) begin
        busy   <= 1'b0;
        done_r <= 1'b0;
        cnt    <= '0;
    end else if (cen) begin
        done_r <= 1'b0;
        if (req.start) begin
            rem  <= '0;
            quo  <= req.dividend;               // Load cycle, no bit yet
            den  <= req.divisor;
            cnt  <= CNT_W'(DIV_W);
            busy <= 1'b1;
        end else if (busy) begin
            if (trial[DIV_W]) begin             // Borrow, keep remainder
                rem <= rem_sh[DIV_W-1:0];
                quo <= {quo[DIV_W-2:0], 1'b0};
            end else begin
                rem <= trial[DIV_W-1:0];
                quo <= {quo[DIV_W-2:0], 1'b1};
            end
            cnt <= cnt - 1'b1;
            if (cnt == CNT_W'(1)) begin         // Last bit, 17 cen after start
                busy   <= 1'b0;
                done_r <= 1'b1;
            end
        end
    end
end

assign rsp.done     = done_r;
assign rsp.quotient = quo;

endmodule

/* hdl/adpcmb_interp.sv */
`timescale 1ns/100ps

module adpcmb_interp #(
    parameter int DIV_W = 16                    // Slope width
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            cen,      // Internal clock enable
    input  logic                            cen_out,  // Output rate enable within cen
    input  logic                            adv,      // Valid with cen_out only
    input  adpcmb_ctrl_pkg::sample_strobe_t sample,
    output adpcmb_ctrl_pkg::div_req_t       div_req,
    input  adpcmb_ctrl_pkg::div_rsp_t       div_rsp,
    output adpcmb_codec_pkg::pcm_t          pcm_out
);

localparam int DN_W = $bits(adpcmb_codec_pkg::dn_t);

adpcmb_codec_pkg::dn_t  pre_dn;      // Running tick count
adpcmb_codec_pkg::dn_t  deltan;      // Count captured on adv
adpcmb_codec_pkg::pcm_t pcm_last;    // Newest decoded sample
adpcmb_codec_pkg::pcm_t pcm_prev;    // The one before
logic                   lat_go;      // Samples just moved
logic                   dx_go;       // Difference ready
logic signed [16:0]     pre_dx;      // Newest minus previous
logic [15:0]            dx_mag;
logic                   start_r;
logic [DIV_W-1:0]       dividend_r;
logic [DIV_W-1:0]       divisor_r;
logic                   next_sign;   // Sign for the pending slope
logic [DIV_W-1:0]       next_step;   // Quotient waiting for adv
logic                   step_sign;
logic [DIV_W-1:0]       step;        // Active slope
adpcmb_codec_pkg::pcm_t pcm_r;

assign dx_mag = pre_dx[16] ? 16'(-pre_dx) : 16'(pre_dx);   // At most 65535

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Slope pipeline at the internal rate
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
always_ff @(posedge clk) begin
    if (!rst_n) begin
        lat_go    <= 1'b0;
        dx_go     <= 1'b0;
        start_r   <= 1'b0;
        pcm_last  <= '0;
        pcm_prev  <= '0;
        next_sign <= 1'b0;
        next_step <= '0;
    end else if (cen) begin
        lat_go  <= sample.stb;
        dx_go   <= lat_go;
        start_r <= dx_go;
        if (sample.stb) begin                   // Shift sample history
            pcm_prev <= pcm_last;
            pcm_last <= sample.pcm;
        end
        if (lat_go)
            pre_dx <= {pcm_last[15], pcm_last} - {pcm_prev[15], pcm_prev};
        if (dx_go) begin                        // Operands for the divider
            dividend_r <= dx_mag[DIV_W-1:0];
            divisor_r  <= {{(DIV_W-DN_W){1'b0}}, deltan};
            next_sign  <= pre_dx[16];
        end
        if (div_rsp.done)
            next_step <= div_rsp.quotient;      // Held until next adv
    end
end

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Interval count and ramp at the output rate
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
always_ff @(posedge clk) begin
    if (!rst_n) begin
        pre_dn    <= adpcmb_codec_pkg::dn_t'(1);
        deltan    <= adpcmb_codec_pkg::dn_t'(1);   // Never divide by zero
        step      <= '0;
        step_sign <= 1'b0;
        pcm_r     <= '0;
    end else if (cen_out) begin
        if (adv) begin
            pre_dn    <= adpcmb_codec_pkg::dn_t'(1);
            deltan    <= pre_dn;                // Includes this adv
            step      <= next_step;
            step_sign <= next_sign;
            pcm_r     <= pcm_last;              // Restart ramp from newest sample
        end else begin
            pre_dn <= pre_dn + 1'b1;
            pcm_r  <= step_sign ? pcm_r - adpcmb_codec_pkg::pcm_t'(step)
                                : pcm_r + adpcmb_codec_pkg::pcm_t'(step);   // Wraps
        end
    end
end

assign div_req.start    = start_r;
assign div_req.dividend = dividend_r;
assign div_req.divisor  = divisor_r;
assign pcm_out          = pcm_r;

endmodule

/* hdl/adpcmb_top.sv */
`timescale 1ns/100ps

module adpcmb_top #(
    parameter int DIV_W = 16                     // Divider and slope width
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         cen,      // Internal clock enable
    input  logic                         cen_out,  // Output rate enable
    input  adpcmb_ctrl_pkg::nib_strobe_t nib_in,   // Code plus advance
    output adpcmb_codec_pkg::pcm_t       pcm_out   // Interpolated output
);

adpcmb_ctrl_pkg::sample_strobe_t sample;   // Decode to interpolator
adpcmb_ctrl_pkg::div_req_t       div_req;  // Interpolator to divider
adpcmb_ctrl_pkg::div_rsp_t       div_rsp;  // Divider back

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decode, interpolate, divide
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
adpcmb_decode u_decode (
    .clk     ( clk     ),
    .rst_n   ( rst_n   ),
    .cen     ( cen     ),
    .nib_in  ( nib_in  ),
    .sample  ( sample  )
);

adpcmb_interp #(
    .DIV_W   ( DIV_W   )
) u_interp (
    .clk     ( clk        ),
    .rst_n   ( rst_n      ),
    .cen     ( cen        ),
    .cen_out ( cen_out    ),
    .adv     ( nib_in.adv ),   // Same strobe starts decode and ramp
    .sample  ( sample     ),
    .div_req ( div_req    ),
    .div_rsp ( div_rsp    ),
    .pcm_out ( pcm_out    )
);

// Slope divider, one bit per cen
adpcmb_div #(
    .DIV_W   ( DIV_W   )
) u_div (
    .clk     ( clk     ),
    .rst_n   ( rst_n   ),
    .cen     ( cen     ),
    .req     ( div_req ),
    .rsp     ( div_rsp )
);

endmodule

/* include/adpcmb_step_table.svh */
`ifndef ADPCMB_STEP_TABLE_SVH
`define ADPCMB_STEP_TABLE_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Step adaptation multipliers, in 1/64 units, indexed by code magnitude
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

localparam logic [7:0] ADPCMB_STEP_MULT [0:7] = '{
    8'd57,      // Small codes shrink the step
    8'd57,
    8'd57,
    8'd57,
    8'd77,      // From here the step grows
    8'd102,
    8'd128,     // Exactly x2
    8'd153
};

`endif

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the ADPCM-B testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module adpcmb_tb \
    -f adpcmb.f \
    -o adpcmb_sim

./obj_dir/adpcmb_sim 2>&1 | tee "$LOG"

# The testbench prints its verdict into the log
if grep -qF '*** TEST FAILED ***' "$LOG"; then
    echo "Simulation failed, see $LOG"
    exit 1
fi

echo "Simulation passed, see $LOG"

/* tests/adpcmb_chk.sv */
`timescale 1ns/100ps

module adpcmb_chk (
    input logic                            clk,
    input logic                            rst_n,
    input logic                            cen,
    input logic                            cen_out,
    input logic                            adv,
    input adpcmb_ctrl_pkg::sample_strobe_t sample,
    input adpcmb_ctrl_pkg::div_req_t       div_req,
    input adpcmb_ctrl_pkg::div_rsp_t       div_rsp,
    input adpcmb_codec_pkg::pcm_t          pcm_out
);

logic       div_busy;    // Divider run in flight
logic [4:0] div_cens;    // Enabled cycles since start

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Divider occupancy as seen from the interpolator
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
always_ff @(posedge clk) begin
    if (!rst_n) begin
        div_busy <= 1'b0;
        div_cens <= '0;
    end else if (cen) begin
        if (div_req.start) begin
            div_busy <= 1'b1;
            div_cens <= '0;
        end else if (div_busy) begin
            div_cens <= div_cens + 5'd1;
            if (div_rsp.done)
                div_busy <= 1'b0;                   // Quotient taken
        end
    end
end

start_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
    (cen && div_req.start) |-> !div_busy)
    else $error("Divider started while a division was running");

done_in_time: assert property (@(posedge clk) disable iff (!rst_n)
    div_busy |-> (div_cens <= 5'd17))
    else $error("Divider done missing 17 enabled cycles after start");

no_stb_on_adv: assert property (@(posedge clk) disable iff (!rst_n)
    !(cen && sample.stb && adv))
    else $error("Decoded sample strobe in the same cycle as an advance");

pcm_on_cen_out: assert property (@(posedge clk) disable iff (!rst_n)
    !$stable(pcm_out) |-> $past(cen_out))
    else $error("Output sample changed without an output enable");

endmodule

bind adpcmb_interp adpcmb_chk u_chk (
    .clk     ( clk     ),
    .rst_n   ( rst_n   ),
    .cen     ( cen     ),
    .cen_out ( cen_out ),
    .adv     ( adv     ),
    .sample  ( sample  ),
    .div_req ( div_req ),
    .div_rsp ( div_rsp ),
    .pcm_out ( pcm_out )
);

/* tests/adpcmb_tb.sv */
`timescale 1ns/100ps

module adpcmb_tb;

localparam int RESET_CYCLES   = 16;
localparam int T1_ADVS        = 4;
localparam int T2_RUN         = 20;     // Codes in each saturating run
localparam int T3_ADVS        = 24;
localparam int T4_ADVS        = 32;
localparam int T5_ADVS        = 16;
localparam int N_ADVS         = T1_ADVS + 2 * T2_RUN + T3_ADVS + T4_ADVS + T5_ADVS;
localparam int TIMEOUT_CYCLES = N_ADVS * 8 * 64 * 2 + RESET_CYCLES;

logic                         clk;
logic                         rst_n;
logic                         cen;
logic                         cen_out;
adpcmb_ctrl_pkg::nib_strobe_t nib_in;
adpcmb_codec_pkg::pcm_t       pcm_out;

int          cycle_cnt    = 0;
int          errors       = 0;
int          checks       = 0;
int          tests_run    = 0;
int          tests_failed = 0;
logic [31:0] lfsr_state   = 32'hcfde;

// Reference model state
int                     m_acc;     // Predictor
int                     m_step;    // Adaptive step
adpcmb_codec_pkg::pcm_t m_s1;      // Newest decoded sample
adpcmb_codec_pkg::pcm_t m_s2;      // The one before
int                     m_nprev;   // Interval captured at last adv
int                     m_cnt;     // Running interval
adpcmb_codec_pkg::pcm_t m_pcm;     // Expected output
adpcmb_codec_pkg::pcm_t m_q;       // Slope magnitude
logic                   m_neg;     // Slope direction
adpcmb_codec_pkg::pcm_t exp_q[$];  // Samples the decoder still owes

adpcmb_top #(
    .DIV_W   ( 16      )
) dut0 (
    .clk     ( clk     ),
    .rst_n   ( rst_n   ),
    .cen     ( cen     ),
    .cen_out ( cen_out ),
    .nib_in  ( nib_in  ),
    .pcm_out ( pcm_out )
);

initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;                      // 4 ns period
end

always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

initial begin : watchdog
    wait (cycle_cnt >= TIMEOUT_CYCLES);
    $display("Timeout after %0d clock cycles, the stimulus never completed", cycle_cnt);
    $display("*** TEST FAILED ***");
    $finish;
end

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Random source, x^32 + x^22 + x^2 + x + 1
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
        lfsr_state = lfsr_next(lfsr_state);     // One step per bit
        v = {v[30:0], lfsr_state[0]};
    end
    return v;
endfunction

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reference model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
function automatic adpcmb_codec_pkg::pcm_t decode_model(input adpcmb_codec_pkg::nibble_t nib);
    int                     diff;
    int                     mult;
    adpcmb_codec_pkg::pcm_t r;
    diff = ((2 * int'(nib.mag) + 1) * m_step) / 8;   // Uses the old step
    m_acc = nib.sign ? m_acc - diff : m_acc + diff;
    if (m_acc > 32767)
        m_acc = 32767;
    else if (m_acc < -32768)
        m_acc = -32768;
    case (nib.mag)
        3'd4:    mult = 77;
        3'd5:    mult = 102;
        3'd6:    mult = 128;
        3'd7:    mult = 153;
        default: mult = 57;                     // Small codes shrink
    endcase
    m_step = (m_step * mult) / 64;
    if (m_step < int'(adpcmb_codec_pkg::STEP_MIN))
        m_step = int'(adpcmb_codec_pkg::STEP_MIN);
    else if (m_step > int'(adpcmb_codec_pkg::STEP_MAX))
        m_step = int'(adpcmb_codec_pkg::STEP_MAX);
    r = 16'(m_acc);
    return r;
endfunction

// One output tick of the top-level rule
task automatic model_out(input logic adv_b, input adpcmb_codec_pkg::nibble_t nib);
    int d;
    int mag;
    if (adv_b) begin
        m_pcm   = m_s1;                         // Ramp restarts at newest
        d       = int'(m_s1) - int'(m_s2);
        mag     = (d < 0) ? -d : d;
        m_neg   = d < 0;
        m_q     = 16'(mag / m_nprev);
        m_nprev = m_cnt;
        m_cnt   = 1;
        m_s2    = m_s1;
        m_s1    = decode_model(nib);
        exp_q.push_back(m_s1);
    end else begin
        m_pcm = m_neg ? m_pcm - m_q : m_pcm + m_q;   // Wraps
        m_cnt = (m_cnt + 1) % 16;
    end
endtask

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Compare tasks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
task automatic check_pcm(input adpcmb_codec_pkg::pcm_t exp);
    checks++;
    if (pcm_out !== exp) begin
        errors++;
        $display("FAILED pcm_out at %0t: got %h, expected %h", $time, pcm_out, exp);
    end
endtask

task automatic check_sample(input adpcmb_codec_pkg::pcm_t exp);
    checks++;
    if (dut0.sample.pcm !== exp) begin
        errors++;
        $display("FAILED sample.pcm at %0t: got %h, expected %h", $time, dut0.sample.pcm, exp);
    end
endtask

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stimulus, one cen tick is two clocks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
task automatic cen_tick(input logic out_b, input logic adv_b,
                        input adpcmb_codec_pkg::nibble_t nib);
    @(posedge clk);
    cen           <= 1'b1;
    cen_out       <= out_b;
    nib_in.adv    <= adv_b;
    nib_in.nibble <= nib;
    @(posedge clk);                             // DUT takes the enabled cycle here
    cen        <= 1'b0;
    cen_out    <= 1'b0;
    nib_in.adv <= 1'b0;
    @(negedge clk);
    if (out_b) begin
        model_out(adv_b, nib);
        check_pcm(m_pcm);
    end
    if (dut0.sample.stb) begin
        if (exp_q.size() == 0) begin
            errors++;
            $display("Decoder strobe at %0t with no code pending", $time);
        end else begin
            check_sample(exp_q.pop_front());
        end
    end
endtask

task automatic out_period(input logic adv_b, input adpcmb_codec_pkg::nibble_t nib);
    cen_tick(1'b1, adv_b, nib);
    repeat (31) cen_tick(1'b0, 1'b0, nib);      // cen_out every 32nd cen
endtask

// Interval of gap output ticks, adv on the last
task automatic send_code(input int gap, input adpcmb_codec_pkg::nibble_t nib);
    repeat (gap - 1) out_period(1'b0, nib);
    out_period(1'b1, nib);
endtask

task automatic report_test(input string name, input int err_before);
    int errs;
    errs = errors - err_before;
    tests_run++;
    if (errs != 0)
        tests_failed++;
    $display("test %0d %s: %0d errors", tests_run, name, errs);
endtask

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Test sequence
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
initial begin : main
    int                        i;
    int                        gap;
    int                        err0;
    logic [31:0]               r;
    adpcmb_codec_pkg::nibble_t nib;
    adpcmb_codec_pkg::pcm_t    prev;
    rst_n   = 1'b0;
    cen     = 1'b0;
    cen_out = 1'b0;
    nib_in  = '0;
    m_acc   = 0;
    m_step  = int'(adpcmb_codec_pkg::STEP_MIN);
    m_s1    = '0;
    m_s2    = '0;
    m_nprev = 1;
    m_cnt   = 1;
    m_pcm   = '0;
    m_q     = '0;
    m_neg   = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);

    // Startup, output held at zero until the second adv
    err0 = errors;
    check_pcm(16'sd0);
    out_period(1'b0, '0);
    check_pcm(16'sd0);
    out_period(1'b0, '0);
    check_pcm(16'sd0);
    r = take_bits(4);
    out_period(1'b1, r[3:0]);                   // First adv, interval 3
    check_pcm(16'sd0);
    out_period(1'b0, '0);
    check_pcm(16'sd0);
    r = take_bits(4);
    out_period(1'b1, r[3:0]);
    for (i = 0; i < T1_ADVS - 2; i++) begin
        gap = 1 + int'(take_bits(3));
        r   = take_bits(4);
        send_code(gap, r[3:0]);
    end
    report_test("startup", err0);

    // Long runs that pin the step and the sample limits
    err0 = errors;
    for (i = 0; i < T2_RUN; i++)
        send_code(1, 4'h7);
    check_sample(16'sh7fff);
    for (i = 0; i < T2_RUN; i++)
        send_code(1, 4'hf);
    check_sample(-16'sh8000);
    report_test("saturation", err0);

    // Output at each adv is the previous decoded sample
    err0 = errors;
    for (i = 0; i < T3_ADVS; i++) begin
        prev = m_s1;
        gap  = 1 + int'(take_bits(3));
        r    = take_bits(4);
        send_code(gap, r[3:0]);
        check_pcm(prev);
    end
    report_test("adv_sample", err0);

    // Ramps over random intervals of 1 to 8 ticks
    err0 = errors;
    for (i = 0; i < T4_ADVS; i++) begin
        gap = 1 + int'(take_bits(3));
        r   = take_bits(4);
        send_code(gap, r[3:0]);
    end
    report_test("ramp", err0);

    // Codes 0 and 8 in turn give small mirrored steps
    err0 = errors;
    for (i = 0; i < T5_ADVS; i++) begin
        gap = 1 + int'(take_bits(3));
        nib = (i % 2 == 0) ? 4'h0 : 4'h8;
        send_code(gap, nib);
    end
    report_test("alternating", err0);

    if (exp_q.size() != 0) begin
        errors++;
        $display("Decoder never produced %0d of the coded samples", exp_q.size());
    end
    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
        $display("*** TEST PASSED ***");
    end else begin
        $display("*** TEST FAILED ***");
    end
    $finish;
end

endmodule
